// File: include/pulse_defines.svh
`ifndef PULSE_DEFINES_SVH
`define PULSE_DEFINES_SVH

// converter words
`define ADC_WIDTH       14
`define ADC_MIDSCALE    8192            // sign boundary of the converter code
`define ADC_FULLSCALE   16384           // inversion reference

// detection
`define PEAK_THRESHOLD  2760            // peak must be strictly above
`define PEAK_LIMIT      8000            // at or above gives a zero record

// sample window geometry, tap 0 is the newest entry
`define WINDOW_DEPTH    26
`define PEAK_TAP        24
`define PRE_TAP         25              // one sample older than the peak
`define POST_TAP        23              // one sample newer than the peak
`define TAIL_TAP        0

// time base and readout
`define TIME_WIDTH      26
`define TIME_WRAP       50000000        // one second at 50 MHz
`define OUT_WIDTH       32

`endif

// File: hdl/adc_pkg.sv
`default_nettype none
`include "pulse_defines.svh"

package adc_pkg;

    // raw converter code and the inverted value held in the window
    typedef logic [`ADC_WIDTH-1:0] sample_t;

    // shift window, element 0 is the newest sample
    typedef sample_t [`WINDOW_DEPTH-1:0] window_t;

endpackage

`default_nettype wire

// File: hdl/event_pkg.sv
`default_nettype none
`include "pulse_defines.svh"

package event_pkg;

    // free-running timestamp
    typedef logic [`TIME_WIDTH-1:0] time_t;

    // one detected pulse
    typedef struct packed {
        adc_pkg::sample_t peak;     // raw peak sample or zero over the limit
        adc_pkg::sample_t tail;     // newest window entry at detection
        time_t            stamp;    // time base value at detection
    } pulse_rec_t;

    // channel number, 0 = A and 1 = B
    typedef logic chan_t;

    // packed readout word toward the processor
    typedef logic [`OUT_WIDTH-1:0] word_t;

endpackage

`default_nettype wire

// File: hdl/pulse_if.sv
`timescale 1ns/1ns
`default_nettype none

// ======================================================================
// detector to arbiter request channel
// ======================================================================
interface pulse_req_if;
    logic                 req;      // pending record waiting for grant
    event_pkg::pulse_rec_t rec;     // held stable while req is high
    event_pkg::chan_t     chan;     // fixed per detector
    logic                 grant;    // transfer on this edge

    modport detector (
        output req,
        output rec,
        output chan,
        input  grant
    );

    modport arbiter (
        input  req,
        input  rec,
        input  chan,
        output grant
    );
endinterface

// ======================================================================
// arbiter to result bank write port
// ======================================================================
interface bank_wr_if;
    logic                  we;      // write at this edge
    event_pkg::chan_t      chan;    // bank slot
    event_pkg::pulse_rec_t rec;

    modport source (output we, output chan, output rec);
    modport sink   (input we, input chan, input rec);
endinterface

`default_nettype wire

// File: hdl/time_base.sv
`timescale 1ns/1ns
`default_nettype none
`include "pulse_defines.svh"

module time_base (
    input  wire              ADA_DCO,
    input  wire              hps_fpga_reset_n,
    output event_pkg::time_t stamp
);

    // last count before returning to zero
    localparam event_pkg::time_t WRAP_LAST = event_pkg::time_t'(`TIME_WRAP - 1);

    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            stamp <= '0;
        end
        else if (stamp == WRAP_LAST)
        begin
            stamp <= '0;                // one second period
        end
        else
        begin
            stamp <= stamp + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hdl/pulse_detector.sv
`timescale 1ns/1ns
`default_nettype none
`include "pulse_defines.svh"

module pulse_detector #(
    parameter event_pkg::chan_t CHAN = 1'b0     // placed on req.chan
) (
    input  wire                   ADA_DCO,
    input  wire                   hps_fpga_reset_n,
    input  wire adc_pkg::sample_t adc_d,
    input  wire event_pkg::time_t stamp,
    pulse_req_if.detector         req
);

    adc_pkg::window_t      win;         // [0] newest .. [25] oldest
    adc_pkg::sample_t      inv_s;       // inverted incoming sample
    adc_pkg::sample_t      pre_s;
    adc_pkg::sample_t      peak_s;
    adc_pkg::sample_t      post_s;
    adc_pkg::sample_t      tail_s;
    logic                  sample_ok;   // negative half of the code range
    logic                  hit;         // qualified pulse this edge
    logic                  accept;      // hit and room in the pending slot
    event_pkg::pulse_rec_t new_rec;

    // ==================================================================
    // window taps and pulse test
    // ==================================================================
    assign pre_s  = win[`PRE_TAP];
    assign peak_s = win[`PEAK_TAP];
    assign post_s = win[`POST_TAP];
    assign tail_s = win[`TAIL_TAP];      // 24 samples after the peak

    assign sample_ok = (adc_d >= `ADC_MIDSCALE);
    assign inv_s     = adc_pkg::sample_t'(`ADC_FULLSCALE - adc_d);

    // local max over the neighbours and above the floor
    assign hit = sample_ok
              && (pre_s <= peak_s)
              && (peak_s >= post_s)
              && (peak_s > `PEAK_THRESHOLD);

    // blocked while an old record waits ungranted
    assign accept = hit && (!req.req || req.grant);

    always_comb
    begin
        new_rec.stamp = stamp;
        if (peak_s >= `PEAK_LIMIT)
        begin
            new_rec.peak = '0;          // saturated pulse
            new_rec.tail = '0;
        end
        else
        begin
            new_rec.peak = peak_s;
            new_rec.tail = tail_s;
        end
    end

    // ==================================================================
    // window shift and pending request
    // ==================================================================
    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            win     <= '0;
            req.req <= 1'b0;
        end
        else
        begin
            if (sample_ok)
            begin
                win <= {win[`WINDOW_DEPTH-2:0], inv_s};   // positive codes hold
            end
            if (accept)
            begin
                req.req <= 1'b1;        // new or replacing record
            end
            else if (req.grant)
            begin
                req.req <= 1'b0;        // taken by the arbiter
            end
        end
    end

    always_ff @(posedge ADA_DCO)
    begin
        if (accept)
        begin
            req.rec <= new_rec;
        end
    end

    assign req.chan = CHAN;

endmodule

`default_nettype wire

// File: hdl/event_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module event_arbiter (
    input  wire          ADA_DCO,
    input  wire          hps_fpga_reset_n,
    pulse_req_if.arbiter req_a,
    pulse_req_if.arbiter req_b,
    bank_wr_if.source    wr
);

    event_pkg::chan_t last_chan;        // channel granted most recently
    logic             gnt_a;
    logic             gnt_b;

    // ==================================================================
    // round robin grant, combinational in the request cycle
    // ==================================================================
    always_comb
    begin
        // a wins alone or on a tie when b went last
        gnt_a = req_a.req && (!req_b.req || (last_chan == 1'b1));
        gnt_b = req_b.req && !gnt_a;
    end

    assign req_a.grant = gnt_a;
    assign req_b.grant = gnt_b;

    // granted record onto the bank port
    assign wr.we   = gnt_a | gnt_b;
    assign wr.chan = gnt_b ? req_b.chan : req_a.chan;
    assign wr.rec  = gnt_b ? req_b.rec  : req_a.rec;

    // ==================================================================
    // last grant pointer
    // ==================================================================
    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            last_chan <= 1'b1;          // first tie goes to a
        end
        else if (gnt_a || gnt_b)
        begin
            last_chan <= event_pkg::chan_t'(gnt_b);
        end
    end

endmodule

`default_nettype wire

// File: hdl/result_bank.sv
`timescale 1ns/1ns
`default_nettype none
`include "pulse_defines.svh"

module result_bank (
    input  wire              ADA_DCO,
    input  wire              hps_fpga_reset_n,
    bank_wr_if.sink          wr,
    input  wire              hps_read,
    output event_pkg::word_t data_peak_out,
    output event_pkg::word_t data_tail_out,
    output event_pkg::time_t data_time_out
);

    adc_pkg::sample_t [1:0] peak_q;     // indexed by channel
    adc_pkg::sample_t [1:0] tail_q;
    event_pkg::time_t       time_q;     // stamp of the newest write
    logic                   read_q;     // hps_read one edge ago
    logic                   read_rise;

    // a in the low half and b in the high half, spare bits zero
    function automatic event_pkg::word_t pack_word(input adc_pkg::sample_t lo,
                                                   input adc_pkg::sample_t hi);
        event_pkg::word_t w;
        w = '0;
        w[`ADC_WIDTH-1:0]           = lo;
        w[`OUT_WIDTH/2 +: `ADC_WIDTH] = hi;
        return w;
    endfunction

    // ==================================================================
    // bank write
    // ==================================================================
    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            peak_q <= '0;
            tail_q <= '0;
            time_q <= '0;
        end
        else if (wr.we)
        begin
            peak_q[wr.chan] <= wr.rec.peak;
            tail_q[wr.chan] <= wr.rec.tail;
            time_q          <= wr.rec.stamp;   // shared by both channels
        end
    end

    // ==================================================================
    // readout latch on hps_read rise
    // ==================================================================
    assign read_rise = hps_read && !read_q;

    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            read_q        <= 1'b0;
            data_peak_out <= '0;
            data_tail_out <= '0;
            data_time_out <= '0;
        end
        else
        begin
            read_q <= hps_read;
            if (read_rise)
            begin
                data_peak_out <= pack_word(peak_q[0], peak_q[1]);   // pre-edge bank
                data_tail_out <= pack_word(tail_q[0], tail_q[1]);
                data_time_out <= time_q;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/pulse_top.sv
`timescale 1ns/1ns
`default_nettype none

module pulse_top (
    input  wire                   ADA_DCO,
    input  wire                   hps_fpga_reset_n,
    input  wire adc_pkg::sample_t ada_d,            // channel a converter
    input  wire adc_pkg::sample_t adb_d,            // channel b, same clock
    input  wire                   hps_read,
    output wire event_pkg::word_t data_peak_out,
    output wire event_pkg::word_t data_tail_out,
    output wire event_pkg::time_t data_time_out
);

    event_pkg::time_t stamp;            // common time base

    pulse_req_if req_a ();
    pulse_req_if req_b ();
    bank_wr_if   bank_wr ();

    // ==================================================================
    // time base and per channel detectors
    // ==================================================================
    time_base time_base_i (
        .ADA_DCO          (ADA_DCO),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .stamp            (stamp)
    );

    pulse_detector #(.CHAN(1'b0)) det_a_i (
        .ADA_DCO          (ADA_DCO),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .adc_d            (ada_d),
        .stamp            (stamp),
        .req              (req_a)
    );

    pulse_detector #(.CHAN(1'b1)) det_b_i (
        .ADA_DCO          (ADA_DCO),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .adc_d            (adb_d),
        .stamp            (stamp),
        .req              (req_b)
    );

    // ==================================================================
    // shared bank behind the arbiter
    // ==================================================================
    event_arbiter arbiter_i (
        .ADA_DCO          (ADA_DCO),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .req_a            (req_a),
        .req_b            (req_b),
        .wr               (bank_wr)
    );

    result_bank bank_i (
        .ADA_DCO          (ADA_DCO),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .wr               (bank_wr),
        .hps_read         (hps_read),
        .data_peak_out    (data_peak_out),
        .data_tail_out    (data_tail_out),
        .data_time_out    (data_time_out)
    );

endmodule

`default_nettype wire

// File: verif/pulse_properties.sv
`timescale 1ns/1ns
`default_nettype none

module pulse_properties (
    input wire                        clk,
    input wire                        rst_n,
    input wire                        req_a,
    input wire                        req_b,
    input wire                        gnt_a,
    input wire                        gnt_b,
    input wire                        we,
    input wire event_pkg::pulse_rec_t rec_a,
    input wire event_pkg::pulse_rec_t rec_b
);

    // ==================================================================
    // arbiter rules
    // ==================================================================
    assert property (@(posedge clk) disable iff (!rst_n) !(gnt_a && gnt_b))
        else $error("both grants high together");
    assert property (@(posedge clk) disable iff (!rst_n) gnt_a |-> req_a)
        else $error("grant to a without a request");
    assert property (@(posedge clk) disable iff (!rst_n) gnt_b |-> req_b)
        else $error("grant to b without a request");

    // losing request holds its record
    assert property (@(posedge clk) disable iff (!rst_n)
                     (req_a && !gnt_a) |=> (req_a && $stable(rec_a)))
        else $error("ungranted request on a dropped or changed");
    assert property (@(posedge clk) disable iff (!rst_n)
                     (req_b && !gnt_b) |=> (req_b && $stable(rec_b)))
        else $error("ungranted request on b dropped or changed");

    assert property (@(posedge clk) disable iff (!rst_n) we == (gnt_a || gnt_b))
        else $error("bank write enable differs from the grants");

endmodule

bind event_arbiter pulse_properties props_i (
    .clk   (ADA_DCO),
    .rst_n (hps_fpga_reset_n),
    .req_a (req_a.req),
    .req_b (req_b.req),
    .gnt_a (gnt_a),
    .gnt_b (gnt_b),
    .we    (wr.we),
    .rec_a (req_a.rec),
    .rec_b (req_b.rec)
);

`default_nettype wire

// File: verif/pulse_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "pulse_defines.svh"

module pulse_tb;

    logic                  ADA_DCO;
    logic                  hps_fpga_reset_n;
    adc_pkg::sample_t      ada_d;
    adc_pkg::sample_t      adb_d;
    logic                  hps_read;
    event_pkg::word_t      data_peak_out;
    event_pkg::word_t      data_tail_out;
    event_pkg::time_t      data_time_out;

    // reference model state
    adc_pkg::window_t      m_win [2];
    logic                  m_req [2];
    event_pkg::pulse_rec_t m_rec [2];
    logic                  m_last;          // 1 = b granted last
    adc_pkg::sample_t      m_peak [2];
    adc_pkg::sample_t      m_tail [2];
    event_pkg::time_t      m_time;
    event_pkg::time_t      m_stamp;         // own cycle count since reset
    logic                  m_read_q;
    event_pkg::word_t      m_peak_out;
    event_pkg::word_t      m_tail_out;
    event_pkg::time_t      m_time_out;
    int                    m_reads;

    adc_pkg::sample_t      shape_q [2][$];  // queued pulse codes per channel
    int                    checks;
    int                    errors;
    int                    timeouts;

    pulse_top dut_i (.*);

    always #4 ADA_DCO = ~ADA_DCO;           // 8 ns period

    // a in bits 13..0, b in bits 29..16
    function automatic event_pkg::word_t pair_word(adc_pkg::sample_t a, adc_pkg::sample_t b);
        return {2'b00, b, 2'b00, a};
    endfunction

    function automatic adc_pkg::sample_t to_code(int v);
        return adc_pkg::sample_t'(`ADC_FULLSCALE - v);  // window value back to raw code
    endfunction

    // ==================================================================
    // cycle model, updated at every clock edge
    // ==================================================================
    always @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin : model
        adc_pkg::sample_t      s [2];
        adc_pkg::sample_t      pk;
        logic                  g [2];
        logic                  hit;
        event_pkg::pulse_rec_t nr;
        if (!hps_fpga_reset_n)
        begin
            for (int c = 0; c < 2; c++)
            begin
                m_win[c]  = '0;
                m_req[c]  = 1'b0;
                m_rec[c]  = '0;
                m_peak[c] = '0;
                m_tail[c] = '0;
            end
            m_last = 1'b1;
            m_time = '0;
            m_stamp = '0;
            m_read_q = 1'b0;
            m_peak_out = '0;
            m_tail_out = '0;
            m_time_out = '0;
        end
        else
        begin
            s[0] = ada_d;
            s[1] = adb_d;
            if (hps_read && !m_read_q)
            begin
                m_peak_out = pair_word(m_peak[0], m_peak[1]);   // bank before this edge
                m_tail_out = pair_word(m_tail[0], m_tail[1]);
                m_time_out = m_time;
                m_reads++;
            end
            m_read_q = hps_read;
            g[0] = m_req[0] && (!m_req[1] || m_last);
            g[1] = m_req[1] && !g[0];
            for (int c = 0; c < 2; c++)
            begin
                if (g[c])
                begin
                    m_peak[c] = m_rec[c].peak;
                    m_tail[c] = m_rec[c].tail;
                    m_time    = m_rec[c].stamp;
                    m_last    = (c == 1);
                end
            end
            for (int c = 0; c < 2; c++)
            begin
                pk  = m_win[c][`PEAK_TAP];
                hit = (s[c] >= `ADC_MIDSCALE) && (m_win[c][`PRE_TAP] <= pk)
                   && (pk >= m_win[c][`POST_TAP]) && (pk > `PEAK_THRESHOLD);
                if (hit && (!m_req[c] || g[c]))
                begin
                    nr.stamp = m_stamp;
                    nr.peak  = (pk >= `PEAK_LIMIT) ? '0 : pk;
                    nr.tail  = (pk >= `PEAK_LIMIT) ? '0 : m_win[c][`TAIL_TAP];
                    m_rec[c] = nr;
                    m_req[c] = 1'b1;
                end
                else if (g[c])
                begin
                    m_req[c] = 1'b0;
                end
                if (s[c] >= `ADC_MIDSCALE)
                begin
                    m_win[c] = {m_win[c][`WINDOW_DEPTH-2:0], to_code(int'(s[c]))};
                end
            end
            m_stamp = (m_stamp == event_pkg::time_t'(`TIME_WRAP - 1)) ? '0 : m_stamp + 1'b1;
        end
    end

    // ==================================================================
    // stimulus on the falling edge
    // ==================================================================
    always @(negedge ADA_DCO)
    begin
        for (int c = 0; c < 2; c++)
        begin
            adc_pkg::sample_t s;
            if (shape_q[c].size() > 0)
                s = shape_q[c].pop_front();
            else if ($urandom % 16 == 0)
                s = adc_pkg::sample_t'($urandom % `ADC_MIDSCALE);  // ignored code
            else
                s = to_code(int'($urandom % 1000));                // quiet baseline
            if (c == 0)
                ada_d = s;
            else
                adb_d = s;
        end
    end

    // rise, peak held for 1 + flat samples, fall
    // clean pulses carry no stray negative codes and end in a full window
    // of quiet samples, so their detection edge is fixed
    task automatic push_pulse(int c, int peak, int flat, bit clean);
        int v;
        for (int k = -4; k <= 4; k++)
        begin
            v = peak * (5 - ((k < 0) ? -k : k)) / 5;
            shape_q[c].push_back(to_code(v));
            if (k == 0)
            begin
                repeat (flat)
                    shape_q[c].push_back(to_code(v));   // plateau, one hit per sample
            end
            if (!clean && $urandom % 4 == 0)
                shape_q[c].push_back(adc_pkg::sample_t'($urandom % `ADC_MIDSCALE));
        end
        if (clean)
        begin
            repeat (`WINDOW_DEPTH)
                shape_q[c].push_back(to_code(1 + int'($urandom % 999)));
        end
    endtask

    function automatic int pick_peak();
        int r;
        r = $urandom % 8;
        if (r == 0)
            return `PEAK_LIMIT + int'($urandom % 193);                 // saturated
        if (r == 1)
            return 200 + int'($urandom % (`PEAK_THRESHOLD - 199));     // too small
        return `PEAK_THRESHOLD + 1 + int'($urandom % (`PEAK_LIMIT - `PEAK_THRESHOLD - 1));
    endfunction

    task automatic check_word(string name, event_pkg::word_t got, event_pkg::word_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[ERROR] %0t ns %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_time(string name, event_pkg::time_t got, event_pkg::time_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[ERROR] %0t ns %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // pulse hps_read and wait for the model to see the rise
    task automatic do_read();
        int start;
        int n;
        start = m_reads;
        n = 0;
        hps_read = 1'b1;
        while (m_reads == start && n < 10)
        begin
            @(negedge ADA_DCO);
            n++;
        end
        hps_read = 1'b0;
        if (m_reads == start)
        begin
            timeouts++;
            $display("timeout: readout never latched at %0t ns", $time);
        end
        else
        begin
            check_word("data_peak_out", data_peak_out, m_peak_out);
            check_word("data_tail_out", data_tail_out, m_tail_out);
            check_time("data_time_out", data_time_out, m_time_out);
        end
        @(negedge ADA_DCO);     // low again before the next rise
    endtask

    // ==================================================================
    // test sequence
    // ==================================================================
    initial
    begin
        int r;
        void'($urandom(32'ha024_7894));
        ADA_DCO = 1'b0;
        hps_fpga_reset_n = 1'b0;
        ada_d = to_code(1);
        adb_d = to_code(1);
        hps_read = 1'b0;
        checks = 0;
        errors = 0;
        timeouts = 0;
        repeat (5) @(negedge ADA_DCO);
        hps_fpga_reset_n = 1'b1;

        do_read();                              // nothing captured yet
        check_word("data_peak_out", data_peak_out, '0);
        check_word("data_tail_out", data_tail_out, '0);
        check_time("data_time_out", data_time_out, '0);

        push_pulse(0, 5000, 0, 1'b0);           // a alone
        repeat (50) @(negedge ADA_DCO);
        do_read();
        push_pulse(0, 8100, 0, 1'b0);           // over the limit
        repeat (50) @(negedge ADA_DCO);
        do_read();
        push_pulse(0, 2000, 0, 1'b0);           // under the threshold
        repeat (50) @(negedge ADA_DCO);
        do_read();
        shape_q[0].delete();
        shape_q[1].delete();
        push_pulse(0, 4000, 0, 1'b1);           // same cycle on both
        push_pulse(1, 6000, 0, 1'b1);
        repeat (50) @(negedge ADA_DCO);
        do_read();
        shape_q[0].delete();
        shape_q[1].delete();
        push_pulse(0, 3000, 1, 1'b1);           // plateau tie, a loses and drops its second hit
        push_pulse(1, 7000, 1, 1'b1);
        repeat (50) @(negedge ADA_DCO);
        do_read();

        for (int i = 0; i < 400; i++)
        begin
            r = $urandom % 4;
            if (r == 0 || r == 2)
                push_pulse(0, pick_peak(), int'($urandom % 3), 1'b0);
            if (r == 1 || r == 2)
                push_pulse(1, pick_peak(), int'($urandom % 3), 1'b0);
            repeat (1 + $urandom % 30) @(negedge ADA_DCO);
            if ($urandom % 3 == 0)
                do_read();
        end
        do_read();

        $display("checks %0d  mismatches %0d  timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+include
hdl/adc_pkg.sv
hdl/event_pkg.sv
hdl/pulse_if.sv
hdl/time_base.sv
hdl/pulse_detector.sv
hdl/event_arbiter.sv
hdl/result_bank.sv
hdl/pulse_top.sv
verif/pulse_properties.sv
verif/pulse_tb.sv

// File: run.sh
#!/bin/sh
# build with verilator, then pass only if the testbench prints its pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f src.f --top-module pulse_tb -o pulse_sim \
    && ./obj_dir/pulse_sim | tee /dev/stderr | grep -q "No errors" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
